//--- Makefile
SRCS := $(filter-out +%,$(shell cat ecc_mem_top.f))
HDRS := logic/ecc_mem_defines.svh bench/ecc_mem_model.svh

.PHONY: run clean

run: obj_dir/Vecc_mem_tb
	./obj_dir/Vecc_mem_tb

obj_dir/Vecc_mem_tb: ecc_mem_top.f $(SRCS) $(HDRS)
	verilator --binary --timing --top-module ecc_mem_tb -f ecc_mem_top.f

clean:
	rm -rf obj_dir

//--- bench/ecc_mem_model.svh
`ifndef ECC_MEM_MODEL_SVH
`define ECC_MEM_MODEL_SVH

// Check column of each data bit, bit 0 first
localparam logic [`ECC_PARITY_W-1:0] COLS [`ECC_DATA_W] = '{
    6'b100011, 6'b100101, 6'b100110, 6'b000111, 6'b101001,
    6'b101010, 6'b001011, 6'b101100, 6'b001101, 6'b001110,
    6'b101111, 6'b110001, 6'b110010, 6'b010011, 6'b110100,
    6'b010101, 6'b010110, 6'b110111, 6'b111000
};

ecc_mem_pkg::ecc_word_t img [`ECC_DEPTH];   // Codewords as stored, flips included
ecc_mem_pkg::ecc_word_t img_inj;
logic                   img_bypass;
logic [15:0]            exp_sbit;
logic [15:0]            exp_dbit;

function automatic logic [`ECC_PARITY_W-1:0] calc_parity(input logic [`ECC_DATA_W-1:0] d);
    logic [`ECC_PARITY_W-1:0] p;
    p = '0;
    for (int i = 0; i < `ECC_DATA_W; i++) begin
        if (d[i])
            p = p ^ COLS[i];
    end
    return p;
endfunction

task automatic apply_write(input logic [`ECC_ADDR_W-1:0] addr, input logic [31:0] data);
    ecc_mem_pkg::ecc_word_t cw;
    cw.data   = data[`ECC_DATA_W-1:0];
    cw.parity = calc_parity(cw.data);
    if (addr < `ECC_REG_CTRL) begin
        img[addr[7:2]] = cw ^ img_inj;
        img_inj        = '0;
    end else if (addr == `ECC_REG_CTRL) begin
        img_bypass = data[0];
    end else if (addr == `ECC_REG_STAT) begin
        exp_sbit = '0;
        exp_dbit = '0;
    end else if (addr == `ECC_REG_INJ) begin
        img_inj = data[$bits(img_inj)-1:0];
    end
endtask

// Expected data and response of a memory read, counters follow
task automatic predict_mem_read(input logic [`ECC_ADDR_W-1:0] addr,
                                output logic [`ECC_DATA_W-1:0] exp_data,
                                output axi_lite_pkg::axi_resp_e exp_resp);
    ecc_mem_pkg::ecc_word_t   cw;
    logic [`ECC_PARITY_W-1:0] syn;
    logic                     hit;
    cw       = img[addr[7:2]];
    syn      = cw.parity ^ calc_parity(cw.data);
    exp_data = cw.data;
    exp_resp = axi_lite_pkg::OKAY;
    hit      = 1'b0;
    if (!img_bypass && syn != '0) begin
        for (int i = 0; i < `ECC_DATA_W; i++) begin
            if (syn == COLS[i]) begin
                exp_data[i] = !exp_data[i];
                hit         = 1'b1;
            end
        end
        if (hit || $onehot(syn)) begin
            if (exp_sbit != 16'hffff)
                exp_sbit = exp_sbit + 16'd1;
        end else begin
            exp_resp = axi_lite_pkg::SLVERR;   // Left uncorrected
            if (exp_dbit != 16'hffff)
                exp_dbit = exp_dbit + 16'd1;
        end
    end
endtask

`endif

//--- bench/ecc_mem_tb.sv
`include "ecc_mem_defines.svh"

module ecc_mem_tb;

    localparam int DRV_DLY    = 10;
    localparam int WAIT_LIMIT = 50;

    logic                  clk;
    logic                  rst_n;
    axi_lite_pkg::axi_aw_t aw;
    logic                  awvalid;
    logic                  awready;
    axi_lite_pkg::axi_w_t  w;
    logic                  wvalid;
    logic                  wready;
    axi_lite_pkg::axi_b_t  b;
    logic                  bvalid;
    logic                  bready;
    axi_lite_pkg::axi_ar_t ar;
    logic                  arvalid;
    logic                  arready;
    axi_lite_pkg::axi_r_t  r;
    logic                  rvalid;
    logic                  rready;
    logic [31:0]           lfsr;

    `include "ecc_mem_model.svh"

    ecc_mem_top dut_i (.*);

    always #50 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1, "Simulation stopped");
    endtask

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [`ECC_ADDR_W-1:0] rand_addr();
        logic [31:0] v;
        v = rand_bits(6);
        return {1'b0, v[5:0], 2'b00};
    endfunction

    task automatic check_rdata(input logic [31:0] got, input logic [`ECC_DATA_W-1:0] exp);
        if (got !== {{(32-`ECC_DATA_W){1'b0}}, exp})
            abort_run($sformatf("Error at %0t: read data %h, expected %h", $time, got, exp));
    endtask

    task automatic check_resp(input axi_lite_pkg::axi_resp_e got,
                              input axi_lite_pkg::axi_resp_e exp, input string chan);
        if (got !== exp)
            abort_run($sformatf("Error at %0t: %s response %s, expected %s",
                                $time, chan, got.name(), exp.name()));
    endtask

    task automatic check_stat(input logic [31:0] got, input logic [15:0] dbit,
                              input logic [15:0] sbit);
        if (got[31:16] !== dbit || got[15:0] !== sbit)
            abort_run($sformatf("Error at %0t: STAT dbit %0d sbit %0d, expected %0d and %0d",
                                $time, got[31:16], got[15:0], dbit, sbit));
    endtask

    function automatic logic chan_ready(input int sel);
        case (sel)
            0:       return awready && wready;
            1:       return bvalid;
            2:       return arready;
            default: return rvalid;
        endcase
    endfunction

    // Polls at falling edges, cycles counts the extra edges
    task automatic wait_chan(input int sel, input string name, output int cycles);
        cycles = 0;
        @(negedge clk);
        while (!chan_ready(sel)) begin
            cycles++;
            if (cycles > WAIT_LIMIT)
                abort_run($sformatf("Timeout: the %s channel stalled", name));
            @(negedge clk);
        end
    endtask

    task automatic write_word(input logic [`ECC_ADDR_W-1:0] waddr, input logic [31:0] wdata,
                              input int b_delay);
        int cycles;
        @(posedge clk);
        #DRV_DLY;
        aw.addr = waddr;
        w.data  = wdata;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        wait_chan(0, "AW/W", cycles);
        @(posedge clk);
        #DRV_DLY;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        repeat (b_delay) begin
            @(posedge clk);
            #DRV_DLY;
        end
        bready = 1'b1;
        wait_chan(1, "B", cycles);
        check_resp(b.resp, axi_lite_pkg::OKAY, "B");
        @(posedge clk);
        #DRV_DLY;
        bready = 1'b0;
        apply_write(waddr, wdata);
    endtask

    task automatic read_word(input logic [`ECC_ADDR_W-1:0] raddr, input int r_delay,
                             output axi_lite_pkg::axi_r_t got);
        int cycles;
        @(posedge clk);
        #DRV_DLY;
        ar.addr = raddr;
        arvalid = 1'b1;
        wait_chan(2, "AR", cycles);
        @(posedge clk);
        #DRV_DLY;
        arvalid = 1'b0;
        wait_chan(3, "R", cycles);
        if (cycles != 2)
            abort_run($sformatf("Error at %0t: rvalid rose %0d cycles after AR, expected 2",
                                $time, cycles));
        repeat (r_delay + 1) begin
            @(posedge clk);
            #DRV_DLY;
        end
        rready = 1'b1;
        wait_chan(3, "R", cycles);
        got = r;
        @(posedge clk);
        #DRV_DLY;
        rready = 1'b0;
    endtask

    task automatic read_check(input logic [`ECC_ADDR_W-1:0] raddr, input int r_delay);
        logic [`ECC_DATA_W-1:0]  exp_data;
        axi_lite_pkg::axi_resp_e exp_resp;
        axi_lite_pkg::axi_r_t    got;
        predict_mem_read(raddr, exp_data, exp_resp);
        read_word(raddr, r_delay, got);
        check_rdata(got.data, exp_data);
        check_resp(got.resp, exp_resp, "R");
    endtask

    task automatic read_stat();
        axi_lite_pkg::axi_r_t got;
        read_word(`ECC_REG_STAT, 0, got);
        check_resp(got.resp, axi_lite_pkg::OKAY, "R");
        check_stat(got.data, exp_dbit, exp_sbit);
    endtask

    // Arm INJ, write a random word, read it back
    task automatic inject_check(input int k1, input int k2);
        logic [`ECC_ADDR_W-1:0] a;
        write_word(`ECC_REG_INJ, (32'd1 << k1) | (32'd1 << k2), 0);
        a = rand_addr();
        write_word(a, rand_bits(32), 0);
        read_check(a, 0);
    endtask

    initial begin
        int                     k;
        logic [31:0]            v;
        logic [`ECC_ADDR_W-1:0] a;
        logic [`ECC_ADDR_W-1:0] a2;
        clk        = 1'b0;
        rst_n      = 1'b0;
        aw         = '0;
        w          = '0;
        w.strb     = 4'hf;
        ar         = '0;
        awvalid    = 1'b0;
        wvalid     = 1'b0;
        bready     = 1'b0;
        arvalid    = 1'b0;
        rready     = 1'b0;
        lfsr       = 32'h4a8d_4a7f;
        img_inj    = '0;
        img_bypass = 1'b0;
        exp_sbit   = '0;
        exp_dbit   = '0;
        repeat (5) @(posedge clk);
        #DRV_DLY;
        rst_n = 1'b1;

        a = '0;
        for (int i = 0; i < `ECC_DEPTH; i++) begin
            write_word(a, rand_bits(32), 0);
            a = a + 9'd4;
        end
        for (int i = 0; i < 32; i++) begin
            write_word(rand_addr(), rand_bits(32), 0);
            read_check(rand_addr(), 0);
        end
        read_stat();

        // Data bit on even rounds, parity bit on odd ones
        for (int i = 0; i < 12; i++) begin
            v = rand_bits(5);
            k = (i % 2 == 0) ? int'(v % 19) : 19 + int'(v % 6);
            inject_check(k, k);
            read_stat();
        end

        for (int i = 0; i < 8; i++) begin
            v = rand_bits(10);
            k = int'(v[4:0] % 25);
            inject_check(k, (k + 1 + int'(v[9:5] % 24)) % 25);
            read_stat();
        end

        write_word(`ECC_REG_CTRL, 32'd1, 0);
        for (int i = 0; i < 8; i++) begin
            v = rand_bits(10);
            inject_check(int'(v[4:0] % 25), int'(v[9:5] % 25));
        end
        read_stat();
        write_word(`ECC_REG_STAT, 32'd0, 0);
        read_stat();
        write_word(`ECC_REG_CTRL, 32'd0, 0);

        // Mixed traffic, concurrent pairs never share a word
        for (int i = 0; i < 40; i++) begin
            v  = rand_bits(12);
            a  = rand_addr();
            a2 = {1'b0, a[7:2] + 6'd1 + {1'b0, v[8:4]}, 2'b00};
            case (v[1:0])
                2'd0:    write_word(a, rand_bits(32), int'(v[3:2]));
                2'd1:    read_check(a, int'(v[3:2]));
                default: begin
                    fork
                        write_word(a, rand_bits(32), int'(v[3:2]));
                        read_check(a2, int'(v[10:9]));
                    join
                end
            endcase
        end
        read_stat();

        $display("All tests passed");
        $finish;
    end

endmodule

//--- ecc_mem_top.f
+incdir+logic
+incdir+bench
logic/axi_lite_pkg.sv
logic/ecc_mem_pkg.sv
logic/ecc_19_cal.sv
logic/ecc_write_path.sv
logic/ecc_read_path.sv
logic/ecc_store.sv
logic/ecc_mem_top.sv
bench/ecc_mem_tb.sv

//--- logic/axi_lite_pkg.sv
`include "ecc_mem_defines.svh"

package axi_lite_pkg;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_e;

    // Write address, AR uses the same layout
    typedef struct packed {
        logic [`ECC_ADDR_W-1:0] addr;
        logic [2:0]             prot;   // Carried only
    } axi_aw_t;

    typedef struct packed {
        logic [`ECC_ADDR_W-1:0] addr;
        logic [2:0]             prot;
    } axi_ar_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;    // Full word writes only
    } axi_w_t;

    typedef struct packed {
        logic [31:0] data;
        axi_resp_e   resp;
    } axi_r_t;

    typedef struct packed {
        axi_resp_e resp;
    } axi_b_t;

endpackage

//--- logic/ecc_19_cal.sv
module ecc_19_cal #(
    parameter DATA_WIDTH   = 19,
    parameter PARITY_WIDTH = 6
) (
    input  logic [DATA_WIDTH-1:0]   data_in,
    output logic [DATA_WIDTH-1:0]   data_out,
    input  logic [PARITY_WIDTH-1:0] parity_in,
    output logic [PARITY_WIDTH-1:0] parity_out,
    input  logic                    bypass,
    output logic [DATA_WIDTH-1:0]   mask,
    output logic                    sbit_err,
    output logic                    dbit_err
);

    // Hamming column per data bit, index 0 last
    localparam logic [DATA_WIDTH-1:0][PARITY_WIDTH-1:0] H_COL = {
        6'b111000, 6'b110111, 6'b010110, 6'b010101,
        6'b110100, 6'b010011, 6'b110010, 6'b110001,
        6'b101111, 6'b001110, 6'b001101, 6'b101100,
        6'b001011, 6'b101010, 6'b101001, 6'b000111,
        6'b100110, 6'b100101, 6'b100011
    };

    logic [PARITY_WIDTH-1:0] syndrome;
    logic                    data_hit;
    logic                    par_hit;
    logic                    nonzero;

    // Parity is the XOR of the columns of all set data bits
    always_comb begin
        parity_out = '0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            if (data_in[i])
                parity_out = parity_out ^ H_COL[i];
        end
    end

    assign syndrome = parity_in ^ parity_out;

    always_comb begin
        for (int i = 0; i < DATA_WIDTH; i++) begin
            mask[i] = (syndrome == H_COL[i]);
        end
    end

    assign nonzero  = |syndrome;
    assign data_hit = |mask;
    assign par_hit  = $onehot(syndrome);     // Flip inside the parity field

    assign data_out = bypass ? data_in : data_in ^ mask;
    assign sbit_err = !bypass && (data_hit || par_hit);
    // Every other nonzero syndrome counts as two flips
    assign dbit_err = !bypass && nonzero && !data_hit && !par_hit;

endmodule

//--- logic/ecc_mem_defines.svh
`ifndef ECC_MEM_DEFINES_SVH
`define ECC_MEM_DEFINES_SVH

// Word layout
`define ECC_DATA_W    19
`define ECC_PARITY_W  6

// Array size and decoded byte address
`define ECC_DEPTH     64
`define ECC_ADDR_W    9

// Register map, above the array window
`define ECC_REG_CTRL  9'h100
`define ECC_REG_STAT  9'h104
`define ECC_REG_INJ   9'h108

`endif

//--- logic/ecc_mem_pkg.sv
`include "ecc_mem_defines.svh"

package ecc_mem_pkg;

    // Stored codeword
    typedef struct packed {
        logic [`ECC_PARITY_W-1:0] parity;
        logic [`ECC_DATA_W-1:0]   data;
    } ecc_word_t;

    // Write request into the store, one per accepted AW/W pair
    typedef struct packed {
        logic                   valid;
        logic [`ECC_ADDR_W-1:0] addr;
        ecc_word_t              code;
        logic [31:0]            wdata;   // Raw data for register writes
    } store_wr_t;

    typedef struct packed {
        logic                   valid;
        logic [`ECC_ADDR_W-1:0] addr;
    } store_rd_t;

    // Registered reply from the store
    typedef struct packed {
        logic        is_mem;
        ecc_word_t   code;
        logic [31:0] rdata;
    } store_rsp_t;

    // Correction events, one cycle each
    typedef struct packed {
        logic sbit;
        logic dbit;
    } ecc_evt_t;

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        RESP
    } rd_state_e;

endpackage

//--- logic/ecc_mem_top.sv
module ecc_mem_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  axi_lite_pkg::axi_aw_t aw,
    input  logic                  awvalid,
    output logic                  awready,
    input  axi_lite_pkg::axi_w_t  w,
    input  logic                  wvalid,
    output logic                  wready,
    output axi_lite_pkg::axi_b_t  b,
    output logic                  bvalid,
    input  logic                  bready,
    input  axi_lite_pkg::axi_ar_t ar,
    input  logic                  arvalid,
    output logic                  arready,
    output axi_lite_pkg::axi_r_t  r,
    output logic                  rvalid,
    input  logic                  rready
);

    ecc_mem_pkg::store_wr_t  wr;
    ecc_mem_pkg::store_rd_t  rd;
    ecc_mem_pkg::store_rsp_t rsp;
    ecc_mem_pkg::ecc_evt_t   evt;
    logic                    bypass;

    ecc_write_path u_write_path (
        .clk     (clk),
        .rst_n   (rst_n),
        .aw      (aw),
        .awvalid (awvalid),
        .awready (awready),
        .w       (w),
        .wvalid  (wvalid),
        .wready  (wready),
        .b       (b),
        .bvalid  (bvalid),
        .bready  (bready),
        .wr      (wr)
    );

    ecc_read_path u_read_path (
        .clk     (clk),
        .rst_n   (rst_n),
        .ar      (ar),
        .arvalid (arvalid),
        .arready (arready),
        .r       (r),
        .rvalid  (rvalid),
        .rready  (rready),
        .rd      (rd),
        .rsp     (rsp),
        .bypass  (bypass),
        .evt     (evt)
    );

    ecc_store u_store (
        .clk    (clk),
        .rst_n  (rst_n),
        .wr     (wr),
        .rd     (rd),
        .evt    (evt),
        .rsp    (rsp),
        .bypass (bypass)
    );

endmodule

//--- logic/ecc_read_path.sv
`include "ecc_mem_defines.svh"

module ecc_read_path (
    input  logic                    clk,
    input  logic                    rst_n,
    input  axi_lite_pkg::axi_ar_t   ar,
    input  logic                    arvalid,
    output logic                    arready,
    output axi_lite_pkg::axi_r_t    r,
    output logic                    rvalid,
    input  logic                    rready,
    output ecc_mem_pkg::store_rd_t  rd,
    input  ecc_mem_pkg::store_rsp_t rsp,
    input  logic                    bypass,
    output ecc_mem_pkg::ecc_evt_t   evt
);

    ecc_mem_pkg::rd_state_e state;
    logic                   ar_fire;
    logic                   rd_vld;
    logic [`ECC_ADDR_W-1:0] rd_addr;
    logic                   rsp_seen;   // Store reply is in
    logic                   take;
    logic [`ECC_DATA_W-1:0] fix_data;
    logic                   sbit;
    logic                   dbit;

    assign ar_fire = arvalid && arready;

    assign rd.valid = rd_vld;
    assign rd.addr  = rd_addr;

    ecc_19_cal #(
        .DATA_WIDTH   (`ECC_DATA_W),
        .PARITY_WIDTH (`ECC_PARITY_W)
    ) u_chk (
        .data_in    (rsp.code.data),
        .data_out   (fix_data),
        .parity_in  (rsp.code.parity),
        .parity_out (),
        .bypass     (bypass),
        .mask       (),
        .sbit_err   (sbit),
        .dbit_err   (dbit)
    );

    // Last FETCH cycle, result goes into R
    assign take     = (state == ecc_mem_pkg::FETCH) && rsp_seen;
    assign evt.sbit = take && rsp.is_mem && sbit;
    assign evt.dbit = take && rsp.is_mem && dbit;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= ecc_mem_pkg::IDLE;
            arready  <= 1'b0;
            rvalid   <= 1'b0;
            rd_vld   <= 1'b0;
            rsp_seen <= 1'b0;
        end else begin
            rd_vld <= 1'b0;
            case (state)
                ecc_mem_pkg::IDLE: begin
                    arready <= 1'b1;
                    if (ar_fire) begin
                        state   <= ecc_mem_pkg::FETCH;
                        arready <= 1'b0;
                        rd_vld  <= 1'b1;
                    end
                end
                ecc_mem_pkg::FETCH: begin
                    rsp_seen <= rd_vld;
                    if (rsp_seen) begin
                        state    <= ecc_mem_pkg::RESP;
                        rvalid   <= 1'b1;
                        rsp_seen <= 1'b0;
                    end
                end
                ecc_mem_pkg::RESP: begin
                    if (rready) begin
                        state   <= ecc_mem_pkg::IDLE;
                        rvalid  <= 1'b0;
                        arready <= 1'b1;
                    end
                end
                default: state <= ecc_mem_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire)
            rd_addr <= ar.addr;
        if (take) begin
            if (rsp.is_mem)
                r.data <= {{(32-`ECC_DATA_W){1'b0}}, fix_data};
            else
                r.data <= rsp.rdata;
            if (rsp.is_mem && dbit)
                r.resp <= axi_lite_pkg::SLVERR;
            else
                r.resp <= axi_lite_pkg::OKAY;
        end
    end

endmodule

//--- logic/ecc_store.sv
`include "ecc_mem_defines.svh"

module ecc_store (
    input  logic                    clk,
    input  logic                    rst_n,
    input  ecc_mem_pkg::store_wr_t  wr,
    input  ecc_mem_pkg::store_rd_t  rd,
    input  ecc_mem_pkg::ecc_evt_t   evt,
    output ecc_mem_pkg::store_rsp_t rsp,
    output logic                    bypass
);

    localparam int IDX_W  = $clog2(`ECC_DEPTH);
    localparam int WORD_W = $bits(ecc_mem_pkg::ecc_word_t);

    ecc_mem_pkg::ecc_word_t mem [`ECC_DEPTH];
    ecc_mem_pkg::ecc_word_t inj;
    logic [15:0]            sbit_cnt;
    logic [15:0]            dbit_cnt;
    logic                   wr_mem;
    logic                   wr_ctrl;
    logic                   wr_stat;
    logic                   wr_inj;
    logic [31:0]            reg_rdata;

    // Array window is everything below CTRL
    assign wr_mem  = wr.valid && (wr.addr < `ECC_REG_CTRL);
    assign wr_ctrl = wr.valid && (wr.addr == `ECC_REG_CTRL);
    assign wr_stat = wr.valid && (wr.addr == `ECC_REG_STAT);
    assign wr_inj  = wr.valid && (wr.addr == `ECC_REG_INJ);

    always_ff @(posedge clk) begin
        if (wr_mem)
            mem[wr.addr[IDX_W+1:2]] <= wr.code ^ inj;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bypass   <= 1'b0;
            inj      <= '0;
            sbit_cnt <= '0;
            dbit_cnt <= '0;
        end else begin
            if (wr_ctrl)
                bypass <= wr.wdata[0];
            if (wr_inj)
                inj <= wr.wdata[WORD_W-1:0];
            else if (wr_mem)
                inj <= '0;          // Mask is used once
            if (wr_stat) begin
                sbit_cnt <= '0;
                dbit_cnt <= '0;
            end else begin
                if (evt.sbit && !(&sbit_cnt))
                    sbit_cnt <= sbit_cnt + 16'd1;
                if (evt.dbit && !(&dbit_cnt))
                    dbit_cnt <= dbit_cnt + 16'd1;
            end
        end
    end

    always_comb begin
        case (rd.addr)
            `ECC_REG_CTRL: reg_rdata = {31'd0, bypass};
            `ECC_REG_STAT: reg_rdata = {dbit_cnt, sbit_cnt};
            `ECC_REG_INJ:  reg_rdata = {{(32-WORD_W){1'b0}}, inj};
            default:       reg_rdata = '0;   // Array and holes
        endcase
    end

    // Old word wins against a write on the same edge
    always_ff @(posedge clk) begin
        if (rd.valid) begin
            rsp.is_mem <= rd.addr < `ECC_REG_CTRL;
            rsp.code   <= mem[rd.addr[IDX_W+1:2]];
            rsp.rdata  <= reg_rdata;
        end
    end

endmodule

//--- logic/ecc_write_path.sv
`include "ecc_mem_defines.svh"

module ecc_write_path (
    input  logic                    clk,
    input  logic                    rst_n,
    input  axi_lite_pkg::axi_aw_t   aw,
    input  logic                    awvalid,
    output logic                    awready,
    input  axi_lite_pkg::axi_w_t    w,
    input  logic                    wvalid,
    output logic                    wready,
    output axi_lite_pkg::axi_b_t    b,
    output logic                    bvalid,
    input  logic                    bready,
    output ecc_mem_pkg::store_wr_t  wr
);

    logic                     wr_fire;
    logic [`ECC_PARITY_W-1:0] parity;

    // Both beats together, and only with no B pending
    assign wr_fire = awvalid && wvalid && !bvalid;
    assign awready = wr_fire;
    assign wready  = wr_fire;

    // Encoder only, check side unused
    ecc_19_cal #(
        .DATA_WIDTH   (`ECC_DATA_W),
        .PARITY_WIDTH (`ECC_PARITY_W)
    ) u_enc (
        .data_in    (w.data[`ECC_DATA_W-1:0]),
        .data_out   (),
        .parity_in  ('0),
        .parity_out (parity),
        .bypass     (1'b0),
        .mask       (),
        .sbit_err   (),
        .dbit_err   ()
    );

    // Store sees the write on the handshake edge
    assign wr.valid       = wr_fire;
    assign wr.addr        = aw.addr;
    assign wr.code.parity = parity;
    assign wr.code.data   = w.data[`ECC_DATA_W-1:0];
    assign wr.wdata       = w.data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bvalid <= 1'b0;
        end else if (wr_fire) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    assign b.resp = axi_lite_pkg::OKAY;    // Writes never fail

endmodule
